/* list.f */
hdl/capture_pkg.sv
hdl/stream_pkg.sv
hdl/afifo.sv
hdl/strobe_capture.sv
hdl/frame_assembler.sv
hdl/capture_top.sv
testbench/capture_checker.sv
testbench/tb_capture_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the run from its log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_capture_top \
	-o sim_capture > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_capture > sim.log 2>&1 || { echo "Simulation exited with an error, see sim.log"; exit 1; }
grep -q "Testbench failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }

/* testbench/tb_capture_top.sv */
// Testbench top for the strobe-capture receiver
// gbl_clk and reset generation
// Bursty strobe clock with seeded random words and frames
// DUT, scoreboard instance and end-of-run verdict

`timescale 1ns/100ps

module tb_capture_top
	import capture_pkg::*, stream_pkg::*;
();

	localparam int unsigned	SEED = 32'h1d83_03c9;

	logic		gbl_clk;
	logic		rd_reset_n;
	logic		smp_clk;
	logic		smp_wr;
	smp_word_t	smp_data;
	logic		smp_sof;
	logic		smp_stb;
	smp_out_t	smp;
	logic		frm_stb;
	frm_sum_t	frm;
	// Stimulus state
	logic		fast_mode;
	logic		prev_valid;
	logic		nxt_valid;
	logic		nxt_sof;
	int		frm_left;
	logic [5:0]	seq;
	int		burst_i;
	// Run control and results
	logic		no_drop;
	logic		run_done;
	int		timeout_errs;
	int		val_errs;
	int		other_errs;
	int		backlog;

	always #10 gbl_clk = ~gbl_clk;

	capture_top DUT (
		.gbl_clk	(gbl_clk),
		.i_rd_reset_n	(rd_reset_n),
		.i_smp_clk	(smp_clk),
		.i_smp_wr	(smp_wr),
		.i_smp_data	(smp_data),
		.i_smp_sof	(smp_sof),
		.o_smp_stb	(smp_stb),
		.o_smp		(smp),
		.o_frm_stb	(frm_stb),
		.o_frm		(frm)
	);

	capture_checker u_checker (
		.gbl_clk	(gbl_clk),
		.i_rd_reset_n	(rd_reset_n),
		.i_smp_clk	(smp_clk),
		.i_smp_wr	(smp_wr),
		.i_smp_data	(smp_data),
		.i_smp_sof	(smp_sof),
		.i_smp_stb	(smp_stb),
		.i_smp		(smp),
		.i_frm_stb	(frm_stb),
		.i_frm		(frm),
		.i_no_drop	(no_drop),
		.i_run_done	(run_done),
		.o_val_errs	(val_errs),
		.o_other_errs	(other_errs),
		.o_backlog	(backlog)
	);

	////////////////////////////////////////////////////////////////////////////
	// Next word on every strobe edge, captured by the DUT on the following one
	always @(posedge smp_clk)
	begin
		// Slow mode never sends two valid words back to back
		if (fast_mode)
			nxt_valid = ($urandom_range(7, 0) != 0);
		else
			nxt_valid = !prev_valid && ($urandom_range(1, 0) == 1);
		nxt_sof = 1'b0;
		if (nxt_valid)
		begin
			if (frm_left == 0)
			begin
				nxt_sof = 1'b1;
				frm_left = $urandom_range(20, 1);
			end
			frm_left = frm_left - 1;
			smp_data <= {6'($urandom), seq};
			seq = seq + 6'd1;
		end
		smp_wr <= nxt_valid;
		smp_sof <= nxt_sof;
		prev_valid = nxt_valid;
	end

	// Strobe clock runs only inside a burst and rests low
	task automatic run_burst(input int n_edges, input int per_lo, input int per_hi);
		int	per;
		int	k;
		for (k = 0; k < n_edges; k++)
		begin
			per = $urandom_range(per_hi, per_lo);
			smp_clk = 1'b1;
			#(per / 2);
			smp_clk = 1'b0;
			#(per - per / 2);
		end
	endtask

	task automatic wait_drain(input int limit);
		int	cyc;
		cyc = 0;
		while (backlog != 0 && cyc < limit)
		begin
			@(negedge gbl_clk);
			cyc++;
		end
		if (backlog != 0)
		begin
			timeout_errs++;
			$display("Timeout: the FIFO did not drain after the slow phase");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	initial
	begin
		void'($urandom(SEED));
		gbl_clk = 1'b0;
		rd_reset_n = 1'b0;
		smp_clk = 1'b0;
		smp_wr = 1'b0;
		smp_data = '0;
		smp_sof = 1'b0;
		fast_mode = 1'b0;
		prev_valid = 1'b0;
		// A few words before the first start of frame
		frm_left = 3;
		seq = '0;
		no_drop = 1'b1;
		run_done = 1'b0;
		timeout_errs = 0;
		repeat (5) @(posedge gbl_clk);
		rd_reset_n <= 1'b1;
		// Idle window, no output strobes expected here
		repeat (20) @(posedge gbl_clk);
		// Slow strobes, the FIFO never fills
		for (burst_i = 0; burst_i < 6; burst_i++)
		begin
			run_burst($urandom_range(30, 10), 30, 40);
			#($urandom_range(300, 100));
		end
		wait_drain(500);
		@(posedge gbl_clk);
		no_drop <= 1'b0;
		// Fast bursts that overflow the FIFO
		fast_mode = 1'b1;
		for (burst_i = 0; burst_i < 8; burst_i++)
		begin
			run_burst($urandom_range(40, 16), 6, 12);
			#($urandom_range(400, 100));
		end
		// Slow tail, so that trailing drops are followed by a delivered word
		fast_mode = 1'b0;
		for (burst_i = 0; burst_i < 2; burst_i++)
		begin
			run_burst($urandom_range(20, 10), 30, 40);
			#($urandom_range(300, 100));
		end
		repeat (200) @(posedge gbl_clk);
		run_done <= 1'b1;
		repeat (2) @(posedge gbl_clk);
		$display("Error counts: %0d value, %0d other, %0d timeout",
			val_errs, other_errs, timeout_errs);
		if (val_errs + other_errs + timeout_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* testbench/capture_checker.sv */
// Scoreboard for the strobe-capture receiver
// Ordered queue of written words, matched against delivered samples
// Reference index, frame length and sum built from delivered samples
// Error counts and backlog reported to the testbench top

`timescale 1ns/100ps

module capture_checker
	import capture_pkg::*, stream_pkg::*;
(
	input  logic		gbl_clk,
	input  logic		i_rd_reset_n,
	// Strobe-side DUT inputs
	input  logic		i_smp_clk,
	input  logic		i_smp_wr,
	input  smp_word_t	i_smp_data,
	input  logic		i_smp_sof,
	// DUT outputs
	input  logic		i_smp_stb,
	input  smp_out_t	i_smp,
	input  logic		i_frm_stb,
	input  frm_sum_t	i_frm,
	// Run control from the testbench top
	input  logic		i_no_drop,
	input  logic		i_run_done,
	output int		o_val_errs,
	output int		o_other_errs,
	output int		o_backlog
);

	// Words seen on the strobe side, oldest first
	smp_word_t		wq_data [$];
	logic			wq_sof [$];
	int			wr_total = 0;
	int			skip_events = 0;
	int			frm_total = 0;
	int			val_errs = 0;
	int			other_errs = 0;
	int			backlog = 0;
	logic			final_done = 1'b0;
	// Open frame as rebuilt from delivered samples
	logic			model_open = 1'b0;
	logic [IDX_W-1:0]	model_cnt = '0;
	logic [SUM_W-1:0]	model_sum = '0;

	assign o_val_errs = val_errs;
	assign o_other_errs = other_errs;
	assign o_backlog = backlog;

	task automatic flag_mismatch(input string what, input int got, input int expd);
		val_errs++;
		$display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, expd);
	endtask

	task automatic flag_problem(input string msg);
		other_errs++;
		$display("At %0t: %s", $time, msg);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One delivered sample against the queue and the frame model
	task automatic check_sample();
		int			pos;
		int			i;
		logic			sof;
		logic [IDX_W-1:0]	exp_idx;
		pos = -1;
		sof = 1'b0;
		// Low data bits carry a write count, so the first match is the right one
		for (i = 0; i < wq_data.size(); i++)
			if (pos < 0 && wq_data[i] == i_smp.data)
				pos = i;
		if (pos < 0)
		begin
			if (wr_total == 0)
				flag_problem("Output strobe before any word was written");
			else
				flag_problem($sformatf("Output word %h matches no written word", i_smp.data));
		end
		else
		begin
			sof = wq_sof[pos];
			if (pos > 0)
				skip_events++;
			if (i_no_drop && pos > 0)
				flag_problem($sformatf("%0d words dropped while strobes were slow", pos));
			// Lost exactly when words were skipped just before this one
			if (i_smp.lost != (pos > 0))
				flag_mismatch("lost flag", int'(i_smp.lost), (pos > 0) ? 1 : 0);
			for (i = 0; i <= pos; i++)
			begin
				void'(wq_data.pop_front());
				void'(wq_sof.pop_front());
			end
		end
		if (sof)
		begin
			exp_idx = '0;
			if (model_open && !i_frm_stb)
				flag_problem("Frame summary missing at start of frame");
			else if (!model_open && i_frm_stb)
				flag_problem("Frame summary emitted with no open frame");
			else if (i_frm_stb)
			begin
				frm_total++;
				if (i_frm.len != model_cnt)
					flag_mismatch("frame length", int'(i_frm.len), int'(model_cnt));
				if (i_frm.sum != model_sum)
					flag_mismatch("frame sum", int'(i_frm.sum), int'(model_sum));
			end
			model_open = 1'b1;
			model_cnt = IDX_W'(1);
			model_sum = SUM_W'(i_smp.data);
		end
		else
		begin
			exp_idx = model_cnt;
			if (i_frm_stb)
				flag_problem("Frame summary on a sample that is not a start of frame");
			model_cnt = model_cnt + IDX_W'(1);
			model_sum = model_sum + SUM_W'(i_smp.data);
		end
		if (i_smp.idx != exp_idx)
			flag_mismatch("sample index", int'(i_smp.idx), int'(exp_idx));
	endtask

	task automatic run_final_checks();
		if (wq_data.size() != 0)
			flag_problem($sformatf("%0d written words never delivered", wq_data.size()));
		if (wr_total == 0)
			flag_problem("No word was written during the run");
		if (skip_events == 0)
			flag_problem("FIFO overflow was never exercised");
		if (frm_total == 0)
			flag_problem("No frame summary was observed");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Strobe side capture of written words
	always @(posedge i_smp_clk)
		if (i_rd_reset_n && i_smp_wr)
		begin
			wq_data.push_back(i_smp_data);
			wq_sof.push_back(i_smp_sof);
			wr_total++;
		end

	// Output side comparison
	always @(posedge gbl_clk or negedge i_rd_reset_n)
		if (!i_rd_reset_n)
		begin
			model_open = 1'b0;
			model_cnt = '0;
			model_sum = '0;
		end
		else
		begin
			if (i_frm_stb && !i_smp_stb)
				flag_problem("Frame strobe without a sample strobe");
			if (i_smp_stb)
				check_sample();
			if (i_run_done && !final_done)
			begin
				final_done = 1'b1;
				run_final_checks();
			end
			backlog = wq_data.size();
		end

endmodule

/* hdl/capture_top.sv */
// Strobe-capture receiver top level
// Capture stage, asynchronous FIFO and frame assembler
// Parameters set here and passed down

`timescale 1ns/100ps

module capture_top
	import capture_pkg::*, stream_pkg::*;
#(
	parameter int	LGFIFO = 3,
	parameter int	NFF = 2,
	parameter bit	WRITE_ON_POSEDGE = 1'b1,
	parameter bit	OPT_REGISTER_READS = 1'b1
)
(
	input  logic		gbl_clk,
	input  logic		i_rd_reset_n,
	// External strobe source
	input  logic		i_smp_clk,
	input  logic		i_smp_wr,
	input  smp_word_t	i_smp_data,
	input  logic		i_smp_sof,
	// Output stream
	output logic		o_smp_stb,
	output smp_out_t	o_smp,
	output logic		o_frm_stb,
	output frm_sum_t	o_frm
);

	// Write side link
	logic		fifo_wr;
	cap_rec_t	fifo_wrec;
	logic		fifo_full;
	// Read side link
	logic		fifo_rd;
	cap_rec_t	fifo_rrec;
	logic		fifo_empty;

	strobe_capture #(
		.WRITE_ON_POSEDGE	(WRITE_ON_POSEDGE)
	) u_capture (
		.i_smp_clk	(i_smp_clk),
		.i_rd_reset_n	(i_rd_reset_n),
		.i_smp_wr	(i_smp_wr),
		.i_smp_data	(i_smp_data),
		.i_smp_sof	(i_smp_sof),
		.i_fifo_full	(fifo_full),
		.o_fifo_wr	(fifo_wr),
		.o_fifo_rec	(fifo_wrec)
	);

	// Write reset shares the read reset, strobe idle while it is low
	afifo #(
		.LGFIFO			(LGFIFO),
		.NFF			(NFF),
		.WRITE_ON_POSEDGE	(WRITE_ON_POSEDGE),
		.OPT_REGISTER_READS	(OPT_REGISTER_READS)
	) u_fifo (
		.i_wclk		(i_smp_clk),
		.i_wr_reset_n	(i_rd_reset_n),
		.i_wr		(fifo_wr),
		.i_wr_data	(fifo_wrec),
		.o_wr_full	(fifo_full),
		.gbl_clk	(gbl_clk),
		.i_rd_reset_n	(i_rd_reset_n),
		.i_rd		(fifo_rd),
		.o_rd_data	(fifo_rrec),
		.o_rd_empty	(fifo_empty)
	);

	frame_assembler u_assembler (
		.gbl_clk	(gbl_clk),
		.i_rd_reset_n	(i_rd_reset_n),
		.i_fifo_empty	(fifo_empty),
		.i_fifo_rec	(fifo_rrec),
		.o_fifo_rd	(fifo_rd),
		.o_smp_stb	(o_smp_stb),
		.o_smp		(o_smp),
		.o_frm_stb	(o_frm_stb),
		.o_frm		(o_frm)
	);

endmodule

/* hdl/frame_assembler.sv */
// Frame assembler in the gbl_clk domain
// Pops every FIFO record as soon as one is present
// Registered sample output with in-frame index
// Frame length and 16-bit data sum, summary on the next start-of-frame

`timescale 1ns/100ps

module frame_assembler
	import capture_pkg::*, stream_pkg::*;
(
	input  logic		gbl_clk,
	input  logic		i_rd_reset_n,
	input  logic		i_fifo_empty,
	input  cap_rec_t	i_fifo_rec,
	output logic		o_fifo_rd,
	output logic		o_smp_stb,
	output smp_out_t	o_smp,
	output logic		o_frm_stb,
	output frm_sum_t	o_frm
);

	logic			rd_fire;
	logic			frm_open;
	// Samples so far in the open frame, also the next index
	logic [IDX_W-1:0]	smp_cnt;
	logic [SUM_W-1:0]	frm_sum;
	logic [SUM_W-1:0]	rec_data_ext;

	// No back-pressure, take whatever is there
	assign rd_fire = !i_fifo_empty;
	assign o_fifo_rd = rd_fire;

	assign rec_data_ext = {{(SUM_W-SMP_W){1'b0}}, i_fifo_rec.data};

	////////////////////////////////////////////////////////////////////////////
	// Strobes and frame accumulation
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
		if (!i_rd_reset_n)
		begin
			o_smp_stb <= 1'b0;
			o_frm_stb <= 1'b0;
			frm_open <= 1'b0;
			smp_cnt <= '0;
			frm_sum <= '0;
		end
		else
		begin
			o_smp_stb <= rd_fire;
			// Summary only once a frame has been opened
			o_frm_stb <= rd_fire && i_fifo_rec.sof && frm_open;
			if (rd_fire)
			begin
				if (i_fifo_rec.sof)
				begin
					// New frame starts with this record
					frm_open <= 1'b1;
					smp_cnt <= IDX_W'(1);
					frm_sum <= rec_data_ext;
				end
				else
				begin
					smp_cnt <= smp_cnt + 1'b1;
					frm_sum <= frm_sum + rec_data_ext;
				end
			end
		end

	// Output payload
	always_ff @(posedge gbl_clk)
		if (rd_fire)
		begin
			o_smp.data <= i_fifo_rec.data;
			o_smp.idx <= i_fifo_rec.sof ? '0 : smp_cnt;
			o_smp.lost <= i_fifo_rec.lost;
			if (i_fifo_rec.sof)
			begin
				o_frm.len <= smp_cnt;
				o_frm.sum <= frm_sum;
			end
		end

	// Summary rides with the first sample of the next frame
	a_frm_with_first: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		o_frm_stb |-> (o_smp_stb && o_smp.idx == '0));

endmodule

/* hdl/strobe_capture.sv */
// Strobe-domain write side of the capture path
// Packs sample word, start-of-frame and loss flag into a FIFO record
// Pending-loss bit for words dropped on a full FIFO

`timescale 1ns/100ps

module strobe_capture
	import capture_pkg::*;
#(
	parameter bit	WRITE_ON_POSEDGE = 1'b1
)
(
	input  logic		i_smp_clk,
	input  logic		i_rd_reset_n,
	input  logic		i_smp_wr,
	input  smp_word_t	i_smp_data,
	input  logic		i_smp_sof,
	input  logic		i_fifo_full,
	output logic		o_fifo_wr,
	output cap_rec_t	o_fifo_rec
);

	logic	wclk;
	logic	lost_pend;
	logic	wr_drop;
	logic	wr_take;

	// Same edge as the FIFO write side
	assign wclk = WRITE_ON_POSEDGE ? i_smp_clk : ~i_smp_clk;

	// Word lost on a full FIFO
	assign wr_drop = i_smp_wr && i_fifo_full;
	// Word accepted, carries any pending loss along
	assign wr_take = i_smp_wr && !i_fifo_full;

	always_ff @(posedge wclk or negedge i_rd_reset_n)
		if (!i_rd_reset_n)
			lost_pend <= 1'b0;
		else if (wr_drop)
			lost_pend <= 1'b1;
		else if (wr_take)
			lost_pend <= 1'b0;

	// FIFO ignores the request itself while full
	assign o_fifo_wr = i_smp_wr;

	always_comb
	begin
		o_fifo_rec.data = i_smp_data;
		o_fifo_rec.sof = i_smp_sof;
		o_fifo_rec.lost = lost_pend;
	end

	// An accepted write never starts a new loss
	a_no_loss_on_take: assert property (@(posedge wclk) disable iff (!i_rd_reset_n)
		wr_take |=> !$rose(lost_pend));

endmodule

/* hdl/afifo.sv */
// Asynchronous FIFO for capture records
// Gray-coded pointers crossing through NFF-stage synchronizers
// Selectable write edge on the strobe clock
// Optional one-entry registered read stage
// Read-domain checks on reset state and data hold

`timescale 1ns/100ps

module afifo
	import capture_pkg::*;
#(
	parameter int	LGFIFO = 3,
	parameter int	NFF = 2,
	parameter bit	WRITE_ON_POSEDGE = 1'b1,
	parameter bit	OPT_REGISTER_READS = 1'b1
)
(
	// Write side, strobe clock
	input  logic		i_wclk,
	input  logic		i_wr_reset_n,
	input  logic		i_wr,
	input  cap_rec_t	i_wr_data,
	output logic		o_wr_full,
	// Read side
	input  logic		gbl_clk,
	input  logic		i_rd_reset_n,
	input  logic		i_rd,
	output cap_rec_t	o_rd_data,
	output logic		o_rd_empty
);

	localparam int DEPTH = 1 << LGFIFO;

	cap_rec_t			mem [DEPTH];
	logic				wclk;
	logic [LGFIFO:0]		wr_addr, next_wr_addr, wgray;
	logic [LGFIFO:0]		rd_addr, next_rd_addr, rgray;
	// Stage 0 is the first flop of each chain
	logic [NFF-1:0][LGFIFO:0]	rgray_sync, wgray_sync;
	logic [LGFIFO:0]		wr_rgray, rd_wgray;
	cap_rec_t			lcl_rd_data;
	logic				lcl_read, lcl_rd_empty;

	////////////////////////////////////////////////////////////////////////////
	// Write side
	generate
		if (WRITE_ON_POSEDGE)
		begin : g_wr_pos
			assign wclk = i_wclk;
		end
		else
		begin : g_wr_neg
			// Invert so that every write block still uses posedge
			assign wclk = ~i_wclk;
		end
	endgenerate

	assign next_wr_addr = wr_addr + 1'b1;

	always_ff @(posedge wclk or negedge i_wr_reset_n)
		if (!i_wr_reset_n)
		begin
			wr_addr <= '0;
			wgray <= '0;
		end
		else if (i_wr && !o_wr_full)
		begin
			wr_addr <= next_wr_addr;
			wgray <= next_wr_addr ^ (next_wr_addr >> 1);
		end

	// Storage
	always_ff @(posedge wclk)
		if (i_wr && !o_wr_full)
			mem[wr_addr[LGFIFO-1:0]] <= i_wr_data;

	////////////////////////////////////////////////////////////////////////////
	// Read side
	assign next_rd_addr = rd_addr + 1'b1;

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
		if (!i_rd_reset_n)
		begin
			rd_addr <= '0;
			rgray <= '0;
		end
		else if (lcl_read && !lcl_rd_empty)
		begin
			rd_addr <= next_rd_addr;
			rgray <= next_rd_addr ^ (next_rd_addr >> 1);
		end

	// Head of the queue, unregistered
	assign lcl_rd_data = mem[rd_addr[LGFIFO-1:0]];

	////////////////////////////////////////////////////////////////////////////
	// Clock crossing
	// Read pointer into the write domain
	always_ff @(posedge wclk or negedge i_wr_reset_n)
		if (!i_wr_reset_n)
			rgray_sync <= '0;
		else
			rgray_sync <= {rgray_sync[NFF-2:0], rgray};

	// Write pointer into the read domain
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
		if (!i_rd_reset_n)
			wgray_sync <= '0;
		else
			wgray_sync <= {wgray_sync[NFF-2:0], wgray};

	assign wr_rgray = rgray_sync[NFF-1];
	assign rd_wgray = wgray_sync[NFF-1];

	// Full when write has lapped read, top two Gray bits flipped
	assign o_wr_full = (wr_rgray == {~wgray[LGFIFO:LGFIFO-1], wgray[LGFIFO-2:0]});
	assign lcl_rd_empty = (rd_wgray == rgray);

	generate
		if (OPT_REGISTER_READS)
		begin : g_reg_rd
			// Refill the output register when it is empty or being taken
			assign lcl_read = o_rd_empty || i_rd;

			always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
				if (!i_rd_reset_n)
					o_rd_empty <= 1'b1;
				else if (lcl_read)
					o_rd_empty <= lcl_rd_empty;

			always_ff @(posedge gbl_clk)
				if (lcl_read)
					o_rd_data <= lcl_rd_data;
		end
		else
		begin : g_comb_rd
			assign lcl_read = i_rd;
			assign o_rd_empty = lcl_rd_empty;
			assign o_rd_data = lcl_rd_data;
		end
	endgenerate

	// First cycle out of reset sees an empty FIFO
	a_empty_after_reset: assert property (@(posedge gbl_clk)
		$rose(i_rd_reset_n) |-> o_rd_empty);

	// Head record holds until it is consumed
	a_rd_data_hold: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(!o_rd_empty && !i_rd) |=> (!o_rd_empty && $stable(o_rd_data)));

endmodule

/* hdl/stream_pkg.sv */
// Output stream definitions in the gbl_clk domain
// Index and sum widths
// Output sample struct and frame summary struct

package stream_pkg;

	import capture_pkg::smp_word_t;

	// In-frame index and frame length width, wraps past 1023
	localparam int IDX_W = 10;

	// Frame data sum width, modulo 2^16
	localparam int SUM_W = 16;

	// Output sample, 23 bits
	typedef struct packed
	{
		smp_word_t		data;
		logic [IDX_W-1:0]	idx;
		logic			lost;
	} smp_out_t;

	// Summary of a closed frame, 26 bits
	typedef struct packed
	{
		logic [IDX_W-1:0]	len;
		logic [SUM_W-1:0]	sum;
	} frm_sum_t;

endpackage

/* hdl/capture_pkg.sv */
// Strobe-domain link definitions
// Sample word width and type
// Record carried through the asynchronous FIFO

package capture_pkg;

	// Width of one sample word from the external source
	localparam int SMP_W = 12;

	// One raw sample word
	typedef logic [SMP_W-1:0] smp_word_t;

	// FIFO record, 14 bits
	// Lost marks that words were dropped just before this one
	typedef struct packed
	{
		smp_word_t	data;
		logic		sof;
		logic		lost;
	} cap_rec_t;

endpackage
